/* Bender.yml */
package:
  name: clock_calendar

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/clock_cal_pkg.sv
      - verilog/tick_timer.sv
      - verilog/set_mode_fsm.sv
      - verilog/time_counter.sv
      - verilog/date_counter.sv
      - verilog/seg_display.sv
      - verilog/clock_calendar.sv
  - target: test
    files:
      - dv/clock_calendar_tb.sv

/* clock_calendar.f */
+incdir+verilog
verilog/clock_cal_pkg.sv
verilog/tick_timer.sv
verilog/set_mode_fsm.sv
verilog/time_counter.sv
verilog/date_counter.sv
verilog/seg_display.sv
verilog/clock_calendar.sv
dv/clock_calendar_tb.sv

/* dv/clock_calendar_tb.sv */
`timescale 1ns/1ns

module clock_calendar_tb;
	localparam int SEC_LIM    = 9;
	localparam int CHANGE_LIM = 3;
	localparam int REPEAT_LIM = 3;
	localparam int BTN_CHANGE = 0;
	localparam int BTN_UP     = 1;
	localparam int BTN_DOWN   = 2;
	localparam int PRESS = REPEAT_LIM + 2; // one pulse plus the sync edge
	localparam int TICK  = SEC_LIM + 1;
	// reset, running, set modes, adjust, 366 rollovers
	localparam int PLAN_CYCLES = 10 + 201 * TICK + 4 * (PRESS + 2 * TICK)
		+ 2 * (4 + 3 * 2 * 124) * PRESS + 5 + 366 * (7 * PRESS + 2 + TICK);
	localparam int CYCLE_LIMIT = 2 * PLAN_CYCLES;

	typedef struct packed {
		logic [1:0]  mode; // 0 run, 1 sec, 2 min, 3 hour
		logic [4:0]  hh;
		logic [5:0]  mm;
		logic [5:0]  ss;
		logic [4:0]  dd;
		logic [3:0]  mo;
		logic [13:0] yr;
	} model_t;

	logic clk;
	logic rst_n;
	logic sw_mode;
	logic btn_change;
	logic btn_up;
	logic btn_down;
	clock_cal_pkg::seg_bank_t  seg;
	clock_cal_pkg::mode_leds_t leds;

	model_t      m;
	int          t_sec, t_chg, t_up, t_dn; // model timer counts
	logic        m_tick, m_chg, m_up, m_dn;
	logic [31:0] lfsr;
	logic [31:0] got_digits;
	logic [31:0] exp_digits;
	int          checks = 0;
	int          errors = 0;
	int          cycles = 0;
	event        tick_ev;

	clock_calendar #(.sec_limit(SEC_LIM), .change_limit(CHANGE_LIM),
			.repeat_limit(REPEAT_LIM)) clock_calendar_inst (
		.clk(clk), .rst_n(rst_n), .sw_mode(sw_mode), .btn_change(btn_change),
		.btn_up(btn_up), .btn_down(btn_down), .seg(seg), .leds(leds));

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// one lfsr step per bit
	function automatic int take_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			v = (v << 1) | lfsr[0];
		end
		return v;
	endfunction

	function automatic int timer_next(input int cnt, input logic en, input int lim);
		return (cnt == lim) ? 0 : (en ? cnt + 1 : cnt);
	endfunction

	function automatic int month_days(input int mo, input int yr);
		logic leap;
		leap = ((yr % 4 == 0) && (yr % 100 != 0)) || (yr % 400 == 0);
		case (mo)
			2:             return leap ? 29 : 28;
			4, 6, 9, 11:   return 30;
			default:       return 31;
		endcase
	endfunction

	function automatic model_t next_day(input model_t s);
		model_t n;
		n = s;
		if (s.dd < month_days(s.mo, s.yr))
			n.dd = s.dd + 1;
		else
		begin
			n.dd = 1;
			n.mo = (s.mo == 12) ? 1 : s.mo + 1;
			if (s.mo == 12)
				n.yr = (s.yr + 1) % 10000; // 9999 wraps to 0
		end
		return n;
	endfunction

	function automatic int step_field(input int v, input int modulo, input logic up,
			input logic dn);
		if (up)
			return (v + 1) % modulo;
		else if (dn)
			return (v + modulo - 1) % modulo;
		return v;
	endfunction

	// next model state for one clock edge
	function automatic model_t ref_step(input model_t s, input logic tick, input logic chg,
			input logic up, input logic dn, input logic cal_view);
		model_t n;
		int     secs;
		n = s;
		case (s.mode)
			2'd0:
				if (tick)
				begin
					secs = s.hh * 3600 + s.mm * 60 + s.ss + 1;
					if (secs == 86400)
					begin
						secs = 0;
						n = next_day(n);
					end
					n.hh = secs / 3600;
					n.mm = (secs / 60) % 60;
					n.ss = secs % 60;
				end
			2'd1: n.ss = step_field(s.ss, 60, up && !cal_view, dn && !cal_view);
			2'd2: n.mm = step_field(s.mm, 60, up && !cal_view, dn && !cal_view);
			2'd3: n.hh = step_field(s.hh, 24, up && !cal_view, dn && !cal_view);
		endcase
		if (chg)
			n.mode = s.mode + 2'd1;
		return n;
	endfunction

	function automatic logic [7:0] bcd2(input int v);
		logic [7:0] r;
		r[7:4] = v / 10;
		r[3:0] = v % 10;
		return r;
	endfunction

	function automatic logic [31:0] expect_digits(input model_t s, input logic cal_view);
		if (cal_view)
			return {bcd2(s.dd), bcd2(s.mo), bcd2(s.yr / 100), bcd2(s.yr % 100)};
		return {bcd2(s.hh), bcd2(s.mm), bcd2(s.ss), 8'hff};
	endfunction

	// segments back to a digit with blank as 15 and anything else 14
	function automatic logic [3:0] seg_digit(input logic [6:0] s);
		case (s)
			7'b1000000: return 4'd0;
			7'b1111001: return 4'd1;
			7'b0100100: return 4'd2;
			7'b0110000: return 4'd3;
			7'b0011001: return 4'd4;
			7'b0010010: return 4'd5;
			7'b0000010: return 4'd6;
			7'b1111000: return 4'd7;
			7'b0000000: return 4'd8;
			7'b0010000: return 4'd9;
			7'b1111111: return 4'd15;
			default:    return 4'd14;
		endcase
	endfunction

	task automatic drive_button(input int which, input logic level);
		case (which)
			BTN_CHANGE: btn_change = level;
			BTN_UP:     btn_up = level;
			default:    btn_down = level;
		endcase
	endtask

	// hold for whole timer periods so the count ends at 0
	task automatic press(input int which, input int pulses);
		@(posedge clk);
		#2;
		drive_button(which, 1'b0);
		repeat (pulses * (((which == BTN_CHANGE) ? CHANGE_LIM : REPEAT_LIM) + 1))
			@(posedge clk);
		#2;
		drive_button(which, 1'b1);
	endtask

	task automatic apply_reset();
		@(posedge clk);
		#2;
		rst_n = 1'b0;
		repeat (4) @(posedge clk);
		#2;
		rst_n = 1'b1;
	endtask

	task automatic show_calendar(input int n);
		@(posedge clk);
		#2;
		sw_mode = 1'b1;
		repeat (n) @(posedge clk);
		#2;
		sw_mode = 1'b0;
	endtask

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// reference model sampling inputs at the edge
	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			m = '0;
			m.dd = 1;
			m.mo = 1;
			m.yr = 2024;
			t_sec = 0;
			t_chg = 0;
			t_up = 0;
			t_dn = 0;
		end
		else
		begin
			m_tick = (t_sec == SEC_LIM);
			m_chg = (t_chg == CHANGE_LIM);
			m_up = (t_up == REPEAT_LIM);
			m_dn = (t_dn == REPEAT_LIM);
			t_sec = timer_next(t_sec, 1'b1, SEC_LIM);
			t_chg = timer_next(t_chg, !btn_change, CHANGE_LIM);
			t_up = timer_next(t_up, !btn_up, REPEAT_LIM);
			t_dn = timer_next(t_dn, !btn_down, REPEAT_LIM);
			m = ref_step(m, m_tick, m_chg, m_up, m_dn, sw_mode);
			if (m_tick)
				->tick_ev;
		end
	end

	// compare the shown view and leds every cycle
	always @(negedge clk)
	begin
		if (rst_n)
		begin
			for (int i = 0; i < 8; i++)
				got_digits[i*4 +: 4] = seg_digit(seg[i]);
			exp_digits = expect_digits(m, sw_mode);
			checks++;
			assert (got_digits == exp_digits)
			else
			begin
				errors++;
				$display("ERROR seg: digits %h, expected %h", got_digits, exp_digits);
			end
			assert (leds == {m.mode == 2'd3, m.mode == 2'd2, m.mode == 2'd1})
			else
			begin
				errors++;
				$display("ERROR leds: %h, expected %h", leds,
					{m.mode == 2'd3, m.mode == 2'd2, m.mode == 2'd1});
			end
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > CYCLE_LIMIT)
		begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	initial
	begin
		rst_n = 1'b0;
		sw_mode = 1'b0;
		btn_change = 1'b1;
		btn_up = 1'b1;
		btn_down = 1'b1;
		lfsr = 32'h493f3c70;
		repeat (4) @(posedge clk);
		#2;
		rst_n = 1'b1;
		show_calendar(3); // 01 01 2024 after reset

		repeat (200) @(tick_ev); // free running through the sec to min carry

		for (int k = 0; k < 4; k++)
		begin
			press(BTN_CHANGE, 1);
			repeat (2) @(tick_ev); // frozen in set modes
		end

		// random adjust with a second pass under the calendar view
		for (int view = 0; view < 2; view++)
		begin
			sw_mode = view[0];
			for (int f = 0; f < 3; f++)
			begin
				press(BTN_CHANGE, 1);
				press(BTN_UP, view ? take_bits(3) + 1 : take_bits(6) + 60);
				press(BTN_DOWN, view ? take_bits(3) + 1 : take_bits(6) + 60);
			end
			press(BTN_CHANGE, 1);
		end
		sw_mode = 1'b0;

		// one day per pass as 23:59:59 then a rollover tick
		apply_reset();
		for (int day = 0; day < 366; day++)
		begin
			press(BTN_CHANGE, 1);
			press(BTN_DOWN, (m.ss + 1) % 60);
			press(BTN_CHANGE, 1);
			press(BTN_DOWN, (m.mm + 1) % 60);
			press(BTN_CHANGE, 1);
			press(BTN_DOWN, (m.hh + 1) % 24);
			press(BTN_CHANGE, 1);
			@(tick_ev);
			show_calendar(1);
		end

		repeat (2) @(posedge clk);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* verilog/clock_cal_cfg.svh */
`ifndef CLOCK_CAL_CFG_SVH
`define CLOCK_CAL_CFG_SVH

// tick timer limits, counted in clock cycles minus one
`define CLK_SEC_LIMIT    49_999_999 // 1 s at 50 MHz
`define CLK_CHANGE_LIMIT 24_999_999 // mode step while change is held
`define CLK_REPEAT_LIMIT 12_499_999 // up/down repeat rate

// wide enough for the largest limit above
`define CLK_TIMER_W 26

// year loaded at reset, four bcd digits
`define CLK_RESET_YEAR 16'h2024

`endif

/* verilog/clock_cal_pkg.sv */
package clock_cal_pkg;

	typedef logic [3:0] bcd_t;

	// run or the field being set
	typedef enum logic [1:0] {
		MODE_RUN,
		MODE_SEC,
		MODE_MIN,
		MODE_HOUR
	} set_mode_e;

	typedef struct packed {
		bcd_t hour_tens;
		bcd_t hour_ones;
		bcd_t min_tens;
		bcd_t min_ones;
		bcd_t sec_tens;
		bcd_t sec_ones;
	} time_bcd_t;

	typedef struct packed {
		bcd_t day_tens;
		bcd_t day_ones;
		bcd_t mon_tens;
		bcd_t mon_ones;
		bcd_t year3;
		bcd_t year2;
		bcd_t year1;
		bcd_t year0;
	} date_bcd_t;

	typedef struct packed {
		logic up;   // one-cycle step pulses
		logic down;
	} adjust_t;

	typedef logic [6:0] seg_t;        // gfedcba, low lights the segment
	typedef seg_t [7:0] seg_bank_t;   // [7] is the leftmost digit

	typedef struct packed {
		logic led_hour;
		logic led_min;
		logic led_sec;
	} mode_leds_t;

endpackage

/* verilog/clock_calendar.sv */
`timescale 1ns/1ns
`include "clock_cal_cfg.svh"

module clock_calendar #(
	parameter logic [`CLK_TIMER_W-1:0] sec_limit    = `CLK_SEC_LIMIT,
	parameter logic [`CLK_TIMER_W-1:0] change_limit = `CLK_CHANGE_LIMIT,
	parameter logic [`CLK_TIMER_W-1:0] repeat_limit = `CLK_REPEAT_LIMIT
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      sw_mode,    // 1 shows the calendar
	input  logic                      btn_change, // buttons read 0 while pressed
	input  logic                      btn_up,
	input  logic                      btn_down,
	output clock_cal_pkg::seg_bank_t  seg,
	output clock_cal_pkg::mode_leds_t leds
);
	logic                     sec_tick;
	logic                     change_pulse;
	clock_cal_pkg::adjust_t   raw_adjust;
	clock_cal_pkg::adjust_t   adjust;
	clock_cal_pkg::set_mode_e mode;
	clock_cal_pkg::time_bcd_t time_now;
	clock_cal_pkg::date_bcd_t date_now;
	logic                     day_rollover;

	tick_timer #(.limit(sec_limit)) sec_timer_inst (
		.clk(clk), .rst_n(rst_n), .en(1'b1), .pulse(sec_tick));

	// holding a button repeats its pulse at the timer rate
	tick_timer #(.limit(change_limit)) change_timer_inst (
		.clk(clk), .rst_n(rst_n), .en(~btn_change), .pulse(change_pulse));
	tick_timer #(.limit(repeat_limit)) up_timer_inst (
		.clk(clk), .rst_n(rst_n), .en(~btn_up), .pulse(raw_adjust.up));
	tick_timer #(.limit(repeat_limit)) down_timer_inst (
		.clk(clk), .rst_n(rst_n), .en(~btn_down), .pulse(raw_adjust.down));

	set_mode_fsm set_mode_fsm_inst (
		.clk(clk), .rst_n(rst_n), .change(change_pulse), .sw_mode(sw_mode),
		.raw_adjust(raw_adjust), .mode(mode), .adjust(adjust), .leds(leds));

	time_counter time_counter_inst (
		.clk(clk), .rst_n(rst_n), .tick(sec_tick), .mode(mode), .adjust(adjust),
		.time_now(time_now), .day_rollover(day_rollover));

	date_counter date_counter_inst (
		.clk(clk), .rst_n(rst_n), .day_rollover(day_rollover), .date_now(date_now));

	seg_display seg_display_inst (
		.sw_mode(sw_mode), .time_now(time_now), .date_now(date_now), .seg(seg));

endmodule

/* verilog/date_counter.sv */
`timescale 1ns/1ns
`include "clock_cal_cfg.svh"

module date_counter (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     day_rollover,
	output clock_cal_pkg::date_bcd_t date_now
);
	logic [7:0]  day_f;
	logic [7:0]  mon_f;
	logic [15:0] year_f;
	logic [7:0]  last_day;
	logic        leap;

	// two bcd digits as a number divisible by 4
	function automatic logic div4(input logic [7:0] val);
		if (val[4])
			return (val[3:0] == 4'd2) || (val[3:0] == 4'd6); // odd tens
		else
			return (val[3:0] == 4'd0) || (val[3:0] == 4'd4) || (val[3:0] == 4'd8);
	endfunction

	function automatic logic [7:0] inc2(input logic [7:0] val);
		if (val[3:0] == 4'd9)
			return {val[7:4] + 4'd1, 4'd0};
		else
			return {val[7:4], val[3:0] + 4'd1};
	endfunction

	// four-digit carry chain, 9999 wraps to 0000
	function automatic logic [15:0] inc_year(input logic [15:0] y);
		logic [15:0] res;
		logic        carry;
		res = y;
		carry = 1'b1;
		for (int i = 0; i < 4; i++)
		begin
			if (carry)
			begin
				if (res[i*4 +: 4] == 4'd9)
					res[i*4 +: 4] = 4'd0;
				else
				begin
					res[i*4 +: 4] = res[i*4 +: 4] + 4'd1;
					carry = 1'b0;
				end
			end
		end
		return res;
	endfunction

	assign day_f  = {date_now.day_tens, date_now.day_ones};
	assign mon_f  = {date_now.mon_tens, date_now.mon_ones};
	assign year_f = {date_now.year3, date_now.year2, date_now.year1, date_now.year0};

	// xx00 years are leap only when the century is divisible by 4
	assign leap = (year_f[7:0] == 8'h00) ? div4(year_f[15:8]) : div4(year_f[7:0]);

	always_comb
	begin
		case (mon_f)
			8'h02:                      last_day = leap ? 8'h29 : 8'h28;
			8'h04, 8'h06, 8'h09, 8'h11: last_day = 8'h30;
			default:                    last_day = 8'h31;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			date_now <= {8'h01, 8'h01, `CLK_RESET_YEAR};
		else if (day_rollover)
		begin
			if (day_f != last_day)
				{date_now.day_tens, date_now.day_ones} <= inc2(day_f);
			else if (mon_f != 8'h12)
				date_now <= {8'h01, inc2(mon_f), year_f};
			else
				date_now <= {8'h01, 8'h01, inc_year(year_f)}; // new year
		end
	end

endmodule

/* verilog/seg_display.sv */
`timescale 1ns/1ns

module seg_display (
	input  logic                     sw_mode,
	input  clock_cal_pkg::time_bcd_t time_now,
	input  clock_cal_pkg::date_bcd_t date_now,
	output clock_cal_pkg::seg_bank_t seg
);
	clock_cal_pkg::bcd_t [7:0] digits; // [7] leftmost

	function automatic clock_cal_pkg::seg_t decode(input clock_cal_pkg::bcd_t d);
		case (d)
			4'd0:    return 7'b1000000;
			4'd1:    return 7'b1111001;
			4'd2:    return 7'b0100100;
			4'd3:    return 7'b0110000;
			4'd4:    return 7'b0011001;
			4'd5:    return 7'b0010010;
			4'd6:    return 7'b0000010;
			4'd7:    return 7'b1111000;
			4'd8:    return 7'b0000000;
			4'd9:    return 7'b0010000;
			default: return 7'b1111111; // blank
		endcase
	endfunction

	// dd mm yyyy, or hh mm ss with two blank digits
	always_comb
	begin
		if (sw_mode)
			digits = date_now;
		else
			digits = {time_now, 4'hf, 4'hf};
	end

	always_comb
	begin
		for (int i = 0; i < 8; i++)
			seg[i] = decode(digits[i]);
	end

endmodule

/* verilog/set_mode_fsm.sv */
`timescale 1ns/1ns

module set_mode_fsm (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      change,
	input  logic                      sw_mode,
	input  clock_cal_pkg::adjust_t    raw_adjust,
	output clock_cal_pkg::set_mode_e  mode,
	output clock_cal_pkg::adjust_t    adjust,
	output clock_cal_pkg::mode_leds_t leds
);
	clock_cal_pkg::set_mode_e mode_next;

	// run -> sec -> min -> hour -> run
	always_comb
	begin
		case (mode)
			clock_cal_pkg::MODE_RUN:  mode_next = clock_cal_pkg::MODE_SEC;
			clock_cal_pkg::MODE_SEC:  mode_next = clock_cal_pkg::MODE_MIN;
			clock_cal_pkg::MODE_MIN:  mode_next = clock_cal_pkg::MODE_HOUR;
			clock_cal_pkg::MODE_HOUR: mode_next = clock_cal_pkg::MODE_RUN;
			default:                  mode_next = clock_cal_pkg::MODE_RUN;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			mode <= clock_cal_pkg::MODE_RUN;
		else if (change)
			mode <= mode_next;
	end

	// one led per set mode, all dark while running
	assign leds.led_sec  = (mode == clock_cal_pkg::MODE_SEC);
	assign leds.led_min  = (mode == clock_cal_pkg::MODE_MIN);
	assign leds.led_hour = (mode == clock_cal_pkg::MODE_HOUR);

	// buttons only touch the time while the clock view is up
	assign adjust = sw_mode ? '0 : raw_adjust;

endmodule

/* verilog/tick_timer.sv */
`timescale 1ns/1ns
`include "clock_cal_cfg.svh"

module tick_timer #(
	parameter logic [`CLK_TIMER_W-1:0] limit = `CLK_SEC_LIMIT
) (
	input  logic clk,
	input  logic rst_n,
	input  logic en,
	output logic pulse
);
	logic [`CLK_TIMER_W-1:0] count;

	// wrap is unconditional so a pulse never lingers past one cycle
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			count <= '0;
		else if (count == limit)
			count <= '0;
		else if (en)
			count <= count + 1'b1; // holds its value while released
	end

	assign pulse = (count == limit);

endmodule

/* verilog/time_counter.sv */
`timescale 1ns/1ns

module time_counter (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     tick,
	input  clock_cal_pkg::set_mode_e mode,
	input  clock_cal_pkg::adjust_t   adjust,
	output clock_cal_pkg::time_bcd_t time_now,
	output logic                     day_rollover
);
	// two-digit fields as {tens, ones}
	logic [7:0] sec_f;
	logic [7:0] min_f;
	logic [7:0] hour_f;

	// next value of a bcd field, max wraps to 00
	function automatic logic [7:0] step_up(input logic [7:0] val, input logic [7:0] max);
		logic [7:0] res;
		if (val == max)
			res = 8'h00;
		else if (val[3:0] == 4'd9)
			res = {val[7:4] + 4'd1, 4'd0};
		else
			res = {val[7:4], val[3:0] + 4'd1};
		return res;
	endfunction

	// previous value, 00 wraps to max
	function automatic logic [7:0] step_down(input logic [7:0] val, input logic [7:0] max);
		logic [7:0] res;
		if (val == 8'h00)
			res = max;
		else if (val[3:0] == 4'd0)
			res = {val[7:4] - 4'd1, 4'd9};
		else
			res = {val[7:4], val[3:0] - 4'd1};
		return res;
	endfunction

	// up wins when both buttons step together
	function automatic logic [7:0] set_step(input logic [7:0] val, input logic [7:0] max,
			input clock_cal_pkg::adjust_t adj);
		logic [7:0] res;
		if (adj.up)
			res = step_up(val, max);
		else if (adj.down)
			res = step_down(val, max);
		else
			res = val;
		return res;
	endfunction

	assign sec_f  = {time_now.sec_tens, time_now.sec_ones};
	assign min_f  = {time_now.min_tens, time_now.min_ones};
	assign hour_f = {time_now.hour_tens, time_now.hour_ones};

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			time_now <= '0;
		else
		begin
			case (mode)
				clock_cal_pkg::MODE_RUN:
					if (tick)
					begin
						{time_now.sec_tens, time_now.sec_ones} <= step_up(sec_f, 8'h59);
						if (sec_f == 8'h59)
						begin
							{time_now.min_tens, time_now.min_ones} <= step_up(min_f, 8'h59);
							if (min_f == 8'h59) // carry into hours
								{time_now.hour_tens, time_now.hour_ones} <= step_up(hour_f, 8'h23);
						end
					end
				clock_cal_pkg::MODE_SEC:
					{time_now.sec_tens, time_now.sec_ones} <= set_step(sec_f, 8'h59, adjust);
				clock_cal_pkg::MODE_MIN:
					{time_now.min_tens, time_now.min_ones} <= set_step(min_f, 8'h59, adjust);
				clock_cal_pkg::MODE_HOUR:
					{time_now.hour_tens, time_now.hour_ones} <= set_step(hour_f, 8'h23, adjust);
			endcase
		end
	end

	// same edge that wraps 23:59:59 to midnight
	assign day_rollover = tick && (mode == clock_cal_pkg::MODE_RUN) && (time_now == 24'h235959);

endmodule
